// File: hdl/hps_io_pkg.sv
/*
 * hps i/o bridge shared definitions
 * bus word and byte widths, host command codes, PS/2 timing
 * and the state encodings of the PS/2 device FSMs
 */

`default_nettype none

package hps_io_pkg;

	// widths with a meaning on the host bus and the core side
	typedef logic [15:0] io_word_t;
	typedef logic [7:0]  byte_t;
	typedef logic [24:0] dl_addr_t;
	typedef logic [31:0] status_t;

	////////////////////////////////////////////////////////////////////
	// host command codes, first word of each command
	////////////////////////////////////////////////////////////////////
	localparam io_word_t cmd_cfg         = 16'h0001;
	localparam io_word_t cmd_joy0        = 16'h0002;
	localparam io_word_t cmd_joy1        = 16'h0003;
	localparam io_word_t cmd_mouse       = 16'h0004;
	localparam io_word_t cmd_kbd         = 16'h0005;
	localparam io_word_t cmd_status      = 16'h001e;
	localparam io_word_t cmd_ps2_read    = 16'h0021;
	localparam io_word_t cmd_file_tx     = 16'h0053;
	localparam io_word_t cmd_file_tx_dat = 16'h0054;
	localparam io_word_t cmd_file_index  = 16'h0055;

	////////////////////////////////////////////////////////////////////
	// PS/2 emulation
	////////////////////////////////////////////////////////////////////
	// clk_sys cycles per half period of the PS/2 clock
	localparam logic [15:0] ps2_div = 16'd2000;

	// log2 of the transmit FIFO depth
	localparam int ps2_fifo_bits = 5;

	// device to host frame
	typedef enum logic [2:0] {
		tx_idle,
		tx_data,
		tx_parity,
		tx_stop,
		tx_finish
	} tx_state_t;

	// host to device frame
	typedef enum logic [2:0] {
		rx_idle,
		rx_request,
		rx_data,
		rx_stop,
		rx_ack
	} rx_state_t;

endpackage

`default_nettype wire

// File: hdl/ps2_host_if.sv
/*
 * byte exchange between the command decoder and one PS/2 device
 * bytes from the host go into the device FIFO, bytes received
 * from the PS/2 host side are read back with a clear pulse
 */

`timescale 1ns/1ps
`default_nettype none

interface ps2_host_if import hps_io_pkg::*; ();

	byte_t wdata;
	logic  we;
	byte_t rdata;
	logic  has_data;
	logic  rd;

	modport host (
		output wdata,
		output we,
		output rd,
		input  rdata,
		input  has_data
	);

	modport dev (
		input  wdata,
		input  we,
		input  rd,
		output rdata,
		output has_data
	);

endinterface

`default_nettype wire

// File: hdl/hps_cmd_decoder.sv
/*
 * host command decoder
 * frames commands on io_enable, counts words on io_strobe,
 * holds the configuration, joystick and status registers,
 * routes keyboard and mouse bytes to the PS/2 devices and
 * returns received PS/2 bytes on io_dout
 */

`timescale 1ns/1ps
`default_nettype none

module hps_cmd_decoder import hps_io_pkg::*; (
	input  wire         clk_sys,
	input  wire         rst_n,

	input  wire         io_enable,
	input  wire         io_strobe,
	input  io_word_t    io_din,
	output io_word_t    io_dout,

	output logic [1:0]  buttons,
	output logic        forced_scandoubler,
	output io_word_t    joystick_0,
	output io_word_t    joystick_1,
	output status_t     status,

	ps2_host_if.host    kbd,
	ps2_host_if.host    mouse
);

	// word index inside the current command, saturating
	logic [3:0] word_cnt;
	io_word_t   cmd;
	logic       payload_stb;

	assign payload_stb = io_enable && io_strobe && (word_cnt != 4'd0);

	//////////////////////////////////////////////////////////////////////
	// framing, registers and read-back
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		// write and read pulses last one cycle
		kbd.we   <= 1'b0;
		kbd.rd   <= 1'b0;
		mouse.we <= 1'b0;
		mouse.rd <= 1'b0;

		if (!rst_n) begin
			word_cnt           <= '0;
			cmd                <= '0;
			io_dout            <= '0;
			buttons            <= '0;
			forced_scandoubler <= 1'b0;
			joystick_0         <= '0;
			joystick_1         <= '0;
			status             <= '0;
		end else if (!io_enable) begin
			word_cnt <= '0;
			io_dout  <= '0;
		end else if (io_strobe) begin
			io_dout <= '0;
			if (word_cnt != 4'hf) begin
				word_cnt <= word_cnt + 4'd1;
			end

			if (word_cnt == 4'd0) begin
				cmd <= io_din;
			end else begin
				case (cmd)
					cmd_cfg: begin
						buttons            <= io_din[1:0];
						forced_scandoubler <= io_din[4];
					end
					cmd_joy0: joystick_0 <= io_din;
					cmd_joy1: joystick_1 <= io_din;
					cmd_mouse: mouse.we <= 1'b1;
					cmd_kbd: kbd.we <= 1'b1;
					// status comes as two halves, low word first
					cmd_status: begin
						if (word_cnt == 4'd1) begin
							status[15:0] <= io_din;
						end else if (word_cnt == 4'd2) begin
							status[31:16] <= io_din;
						end
					end
					// word 1 keyboard, word 2 mouse, bit 8 flags a fresh byte
					cmd_ps2_read: begin
						if (word_cnt == 4'd1) begin
							io_dout <= {7'd0, kbd.has_data, kbd.rdata};
							kbd.rd  <= 1'b1;
						end else if (word_cnt == 4'd2) begin
							io_dout  <= {7'd0, mouse.has_data, mouse.rdata};
							mouse.rd <= 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// byte for the device FIFO, qualified by the we pulse
	always_ff @(posedge clk_sys) begin
		if (payload_stb && (cmd == cmd_kbd)) begin
			kbd.wdata <= io_din[7:0];
		end
		if (payload_stb && (cmd == cmd_mouse)) begin
			mouse.wdata <= io_din[7:0];
		end
	end

	// device side pulses stay inside an open command
	a_ps2_pulse_in_cmd: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		(kbd.we || kbd.rd || mouse.we || mouse.rd) |-> io_enable
	);

endmodule

`default_nettype wire

// File: hdl/file_download.sv
/*
 * file download port
 * follows the host command framing on its own and turns
 * file commands into the ioctl byte stream with a running
 * address and a write strobe for the core
 */

`timescale 1ns/1ps
`default_nettype none

module file_download import hps_io_pkg::*; (
	input  wire       clk_sys,
	input  wire       rst_n,

	input  wire       io_enable,
	input  wire       io_strobe,
	input  io_word_t  io_din,

	output logic      ioctl_download,
	output byte_t     ioctl_index,
	output logic      ioctl_wr,
	output dl_addr_t  ioctl_addr,
	output byte_t     ioctl_dout
);

	logic     has_cmd;
	io_word_t cmd;
	dl_addr_t addr;
	// write strobe stage, ioctl_wr follows one clock later
	logic     wr_stage;
	logic     payload_stb;

	assign payload_stb = io_enable && io_strobe && has_cmd;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			has_cmd        <= 1'b0;
			cmd            <= '0;
			addr           <= '0;
			wr_stage       <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_addr     <= '0;
		end else begin
			ioctl_wr <= wr_stage;
			wr_stage <= 1'b0;

			if (!io_enable) begin
				has_cmd <= 1'b0;
			end else if (io_strobe && !has_cmd) begin
				cmd     <= io_din;
				has_cmd <= 1'b1;
			end else if (payload_stb) begin
				case (cmd)
					// nonzero opens a download, zero closes it
					cmd_file_tx: begin
						if (|io_din) begin
							addr           <= '0;
							ioctl_download <= 1'b1;
						end else begin
							ioctl_addr     <= addr;
							ioctl_download <= 1'b0;
						end
					end
					cmd_file_tx_dat: begin
						ioctl_addr <= addr;
						wr_stage   <= 1'b1;
						addr       <= addr + 25'd1;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (payload_stb && (cmd == cmd_file_index)) begin
			ioctl_index <= io_din[7:0];
		end
		if (payload_stb && (cmd == cmd_file_tx_dat)) begin
			ioctl_dout <= io_din[7:0];
		end
	end

	// the delayed write still lands inside the open download
	a_wr_in_download: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |-> (ioctl_download && $past(ioctl_download))
	);

endmodule

`default_nettype wire

// File: hdl/ps2_device.sv
/*
 * PS/2 device emulation
 * queues host bytes in a 32 entry FIFO and sends them as
 * 11 bit frames with odd parity, receives host to device
 * frames and acknowledges them, all timed by a PS/2 clock
 * divided down from clk_sys
 */

`timescale 1ns/1ps
`default_nettype none

module ps2_device import hps_io_pkg::*; (
	input  wire        clk_sys,
	input  wire        rst_n,

	ps2_host_if.dev    host,

	output logic       ps2_clk_out,
	output logic       ps2_data_out,
	input  wire        ps2_clk_in,
	input  wire        ps2_data_in
);

	// PS/2 clock divider
	logic [15:0] div_cnt;
	logic        clk_ps2;
	logic        ps2_tick;
	logic        ps2_rise;
	logic        ps2_fall;

	// transmit FIFO, extra pointer bit tells full from empty
	byte_t                  fifo_mem [0:(1 << ps2_fifo_bits) - 1];
	logic [ps2_fifo_bits:0] wptr;
	logic [ps2_fifo_bits:0] rptr;
	logic                   fifo_empty;
	logic                   fifo_full;
	logic                   fifo_push;

	logic [1:0] clk_sync;
	logic       dat_sync;
	logic       lines_free;
	logic       rx_start;

	tx_state_t  tx_state;
	rx_state_t  rx_state;
	logic       tx_busy;
	logic       rx_busy;
	logic [3:0] bit_cnt;
	logic [1:0] idle_cnt;
	byte_t      tx_byte;
	logic       parity;
	byte_t      rx_shift;
	byte_t      rdata;
	logic       has_data;

	assign ps2_tick = (div_cnt == ps2_div - 16'd1);
	assign ps2_rise = ps2_tick && !clk_ps2;
	assign ps2_fall = ps2_tick && clk_ps2;

	assign fifo_empty = (wptr == rptr);
	assign fifo_full  = (wptr[ps2_fifo_bits-1:0] == rptr[ps2_fifo_bits-1:0]) &&
		(wptr[ps2_fifo_bits] != rptr[ps2_fifo_bits]);
	assign fifo_push  = host.we && !fifo_full;

	assign tx_busy    = (tx_state != tx_idle);
	assign rx_busy    = (rx_state != rx_idle);
	assign lines_free = clk_sync[1] && clk_sync[0] && dat_sync;
	// host released its clock while holding data low
	assign rx_start   = !rx_busy && !tx_busy && !clk_sync[1] && clk_sync[0] && !dat_sync;

	assign host.rdata    = rdata;
	assign host.has_data = has_data;

	always_ff @(posedge clk_sys) begin
		if (fifo_push) begin
			fifo_mem[wptr[ps2_fifo_bits-1:0]] <= host.wdata;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			div_cnt      <= '0;
			clk_ps2      <= 1'b0;
			clk_sync     <= 2'b11;
			dat_sync     <= 1'b1;
			wptr         <= '0;
			rptr         <= '0;
			tx_state     <= tx_idle;
			rx_state     <= rx_idle;
			bit_cnt      <= '0;
			idle_cnt     <= '0;
			tx_byte      <= '0;
			parity       <= 1'b1;
			rx_shift     <= '0;
			rdata        <= '0;
			has_data     <= 1'b0;
			ps2_clk_out  <= 1'b1;
			ps2_data_out <= 1'b1;
		end else begin
			div_cnt <= ps2_tick ? 16'd0 : div_cnt + 16'd1;
			if (ps2_tick) begin
				clk_ps2 <= !clk_ps2;
			end

			clk_sync <= {clk_sync[0], ps2_clk_in};
			dat_sync <= ps2_data_in;

			if (fifo_push) begin
				wptr <= wptr + 1'b1;
			end
			if (host.rd) begin
				has_data <= 1'b0;
			end

			if (rx_start) begin
				rx_state     <= rx_request;
				ps2_data_out <= 1'b1;
			end

			////////////////////////////////////////////////////////////////
			// bit timing on the rising PS/2 clock
			////////////////////////////////////////////////////////////////
			if (ps2_rise) begin
				ps2_clk_out <= 1'b1;
				if (rx_busy) begin
					case (rx_state)
						rx_request: begin
							rx_state <= rx_data;
							bit_cnt  <= '0;
						end
						// eight data bits, the ninth edge is parity
						rx_data: begin
							if (bit_cnt <= 4'd7) begin
								rx_shift <= {dat_sync, rx_shift[7:1]};
							end else begin
								rx_state <= rx_stop;
							end
							bit_cnt <= bit_cnt + 4'd1;
						end
						rx_stop: begin
							if (dat_sync) begin
								rx_state     <= rx_ack;
								ps2_data_out <= 1'b0;
							end
						end
						rx_ack: begin
							ps2_data_out <= 1'b1;
							rdata        <= rx_shift;
							has_data     <= 1'b1;
							rx_state     <= rx_idle;
						end
						default: rx_state <= rx_idle;
					endcase
				end else begin
					case (tx_state)
						// wait three released periods before a start bit
						tx_idle: begin
							if (!lines_free) begin
								idle_cnt <= '0;
							end else if (idle_cnt != 2'd3) begin
								idle_cnt <= idle_cnt + 2'd1;
							end else if (!fifo_empty) begin
								idle_cnt     <= '0;
								tx_byte      <= fifo_mem[rptr[ps2_fifo_bits-1:0]];
								rptr         <= rptr + 1'b1;
								parity       <= 1'b1;
								bit_cnt      <= '0;
								ps2_data_out <= 1'b0;
								tx_state     <= tx_data;
							end
						end
						tx_data: begin
							ps2_data_out <= tx_byte[0];
							tx_byte      <= {1'b0, tx_byte[7:1]};
							parity       <= parity ^ tx_byte[0];
							bit_cnt      <= bit_cnt + 4'd1;
							if (bit_cnt == 4'd7) begin
								tx_state <= tx_parity;
							end
						end
						tx_parity: begin
							ps2_data_out <= parity;
							tx_state     <= tx_stop;
						end
						tx_stop: begin
							ps2_data_out <= 1'b1;
							tx_state     <= tx_finish;
						end
						tx_finish: tx_state <= tx_idle;
						default: tx_state <= tx_idle;
					endcase
				end
			end

			// clock low pulse for every bit of a frame in flight
			if (ps2_fall) begin
				ps2_clk_out <= !tx_busy && ((rx_state == rx_idle) || (rx_state == rx_request));
			end
		end
	end

	// start conditions sit in separate branches, they must exclude each other
	a_tx_rx_exclusive: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!(tx_busy && rx_busy)
	);

endmodule

`default_nettype wire

// File: hdl/hps_io.sv
/*
 * hps i/o bridge top level
 * host command bus to core registers, file download port
 * and keyboard and mouse PS/2 emulation
 */

`timescale 1ns/1ps
`default_nettype none

module hps_io import hps_io_pkg::*; (
	input  wire        clk_sys,
	input  wire        rst_n,

	// host command bus
	input  wire        io_enable,
	input  wire        io_strobe,
	input  io_word_t   io_din,
	output io_word_t   io_dout,
	output logic       io_wait,

	// core registers
	output logic [1:0] buttons,
	output logic       forced_scandoubler,
	output io_word_t   joystick_0,
	output io_word_t   joystick_1,
	output status_t    status,

	// file download
	output logic       ioctl_download,
	output byte_t      ioctl_index,
	output logic       ioctl_wr,
	output dl_addr_t   ioctl_addr,
	output byte_t      ioctl_dout,
	input  wire        ioctl_wait,

	// PS/2 keyboard
	output logic       ps2_kbd_clk_out,
	output logic       ps2_kbd_data_out,
	input  wire        ps2_kbd_clk_in,
	input  wire        ps2_kbd_data_in,

	// PS/2 mouse
	output logic       ps2_mouse_clk_out,
	output logic       ps2_mouse_data_out,
	input  wire        ps2_mouse_clk_in,
	input  wire        ps2_mouse_data_in
);

	ps2_host_if kbd_if ();
	ps2_host_if mouse_if ();

	// core back-pressure goes straight to the host
	assign io_wait = ioctl_wait;

	hps_cmd_decoder i_hps_cmd_decoder (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.kbd                (kbd_if.host),
		.mouse              (mouse_if.host)
	);

	file_download i_file_download (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.io_enable      (io_enable),
		.io_strobe      (io_strobe),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

	ps2_device i_ps2_kbd (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.host         (kbd_if.dev),
		.ps2_clk_out  (ps2_kbd_clk_out),
		.ps2_data_out (ps2_kbd_data_out),
		.ps2_clk_in   (ps2_kbd_clk_in),
		.ps2_data_in  (ps2_kbd_data_in)
	);

	ps2_device i_ps2_mouse (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.host         (mouse_if.dev),
		.ps2_clk_out  (ps2_mouse_clk_out),
		.ps2_data_out (ps2_mouse_data_out),
		.ps2_clk_in   (ps2_mouse_clk_in),
		.ps2_data_in  (ps2_mouse_data_in)
	);

endmodule

`default_nettype wire

// File: sim/tb_hps_io.sv
/*
 * testbench for the hps i/o bridge
 * drives the host command bus, plays the PS/2 host side and
 * checks the registers, the download port and the PS/2 frames
 */

`timescale 1ns/1ps
`default_nettype none

module tb_hps_io;

	// command codes as the host firmware sends them
	localparam logic [15:0] cmd_cfg         = 16'h0001;
	localparam logic [15:0] cmd_joy0        = 16'h0002;
	localparam logic [15:0] cmd_joy1        = 16'h0003;
	localparam logic [15:0] cmd_mouse       = 16'h0004;
	localparam logic [15:0] cmd_kbd         = 16'h0005;
	localparam logic [15:0] cmd_status      = 16'h001e;
	localparam logic [15:0] cmd_ps2_read    = 16'h0021;
	localparam logic [15:0] cmd_file_tx     = 16'h0053;
	localparam logic [15:0] cmd_file_tx_dat = 16'h0054;
	localparam logic [15:0] cmd_file_index  = 16'h0055;

	localparam int ps2_half      = int'(hps_io_pkg::ps2_div);
	// forty frames of 22 half periods each, plus bus traffic
	localparam int timeout_limit = 40 * 22 * ps2_half + 5000;

	localparam int line_kbd_clk    = 0;
	localparam int line_kbd_data   = 1;
	localparam int line_mouse_clk  = 2;
	localparam int line_mouse_data = 3;

	logic        clk_sys           = 1'b0;
	logic        rst_n             = 1'b0;
	logic        io_enable         = 1'b0;
	logic        io_strobe         = 1'b0;
	logic [15:0] io_din            = '0;
	logic        ioctl_wait        = 1'b0;
	logic        ps2_kbd_clk_in    = 1'b1;
	logic        ps2_kbd_data_in   = 1'b1;
	logic        ps2_mouse_clk_in  = 1'b1;
	logic        ps2_mouse_data_in = 1'b1;

	wire [15:0] io_dout;
	wire        io_wait;
	wire [1:0]  buttons;
	wire        forced_scandoubler;
	wire [15:0] joystick_0;
	wire [15:0] joystick_1;
	wire [31:0] status;
	wire        ioctl_download;
	wire [7:0]  ioctl_index;
	wire        ioctl_wr;
	wire [24:0] ioctl_addr;
	wire [7:0]  ioctl_dout;
	wire        ps2_kbd_clk_out;
	wire        ps2_kbd_data_out;
	wire        ps2_mouse_clk_out;
	wire        ps2_mouse_data_out;

	logic [31:0] lfsr       = 32'ha287_d4d3;
	int          cycle_cnt  = 0;
	int          wr_cnt     = 0;
	logic        kbd_quiet  = 1'b0;
	string       frame_test = "";
	logic [15:0] last_dout  = '0;
	logic [15:0] payload_q[$];
	logic [32:0] dl_exp_q[$];
	logic [10:0] frame_exp_q[$];
	logic [10:0] frame_act_q[$];

	// register model, cfg packed as {scandoubler, buttons}
	logic [31:0] m_cfg    = '0;
	logic [31:0] m_joy0   = '0;
	logic [31:0] m_joy1   = '0;
	logic [31:0] m_status = '0;

	always #50 clk_sys = ~clk_sys;

	hps_io i_hps_io (.*);

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == timeout_limit) begin
			$display("run stopped after %0d cycles without finishing", cycle_cnt);
			$display("Checks failed");
			$fatal(1);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// failure reports, random source and reference functions
	//////////////////////////////////////////////////////////////////////
	task automatic fail_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		$display("** Error %s: expected %0h, actual %0h", name, exp, act);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic fail_text(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	// taps 32, 22, 2, 1, one step per bit
	function automatic logic [7:0] rand_byte();
		logic [7:0] r;
		logic       fb;
		r = '0;
		for (int i = 0; i < 8; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[6:0], fb};
		end
		return r;
	endfunction

	function automatic logic [15:0] rand_word();
		logic [7:0] hi;
		logic [7:0] lo;
		hi = rand_byte();
		lo = rand_byte();
		return {hi, lo};
	endfunction

	// bit 0 goes first on the wire: start, data LSB first, odd parity, stop
	function automatic logic [10:0] ps2_frame(input logic [7:0] b);
		return {1'b1, ~^b, b, 1'b0};
	endfunction

	function automatic logic [31:0] expected_reg(input logic [15:0] cmd, input int idx,
		input logic [15:0] din, input logic [31:0] old);
		case (cmd)
			cmd_cfg:    return {29'd0, din[4], din[1:0]};
			cmd_joy0:   return {16'd0, din};
			cmd_joy1:   return {16'd0, din};
			cmd_status: return (idx == 1) ? {old[31:16], din} : {din, old[15:0]};
			default:    return old;
		endcase
	endfunction

	function automatic logic ps2_line(input int sel);
		case (sel)
			line_kbd_clk:   return ps2_kbd_clk_out;
			line_kbd_data:  return ps2_kbd_data_out;
			line_mouse_clk: return ps2_mouse_clk_out;
			default:        return ps2_mouse_data_out;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// host bus and PS/2 host model
	//////////////////////////////////////////////////////////////////////
	task automatic wait_line(input int sel, input logic level);
		do @(negedge clk_sys); while (ps2_line(sel) !== level);
	endtask

	// one strobed word, held off while the core asks to wait
	task automatic bus_word(input logic [15:0] w);
		@(posedge clk_sys);
		while (io_wait) @(posedge clk_sys);
		io_din    <= w;
		io_strobe <= 1'b1;
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		@(negedge clk_sys);
		last_dout = io_dout;
	endtask

	task automatic bus_command(input logic [15:0] cmd);
		@(posedge clk_sys);
		io_enable <= 1'b1;
		bus_word(cmd);
		while (payload_q.size() > 0) begin
			bus_word(payload_q.pop_front());
		end
		@(posedge clk_sys);
		io_enable <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic reg_write(input logic [15:0] cmd, inout logic [31:0] model);
		logic [15:0] w;
		int          words;
		words = (cmd == cmd_status) ? 2 : 1;
		for (int i = 1; i <= words; i++) begin
			w     = rand_word();
			model = expected_reg(cmd, i, w, model);
			payload_q.push_back(w);
		end
		bus_command(cmd);
	endtask

	task automatic check_regs();
		@(negedge clk_sys);
		assert ({29'd0, forced_scandoubler, buttons} == m_cfg)
			else fail_value("register cfg", m_cfg, {29'd0, forced_scandoubler, buttons});
		assert ({16'd0, joystick_0} == m_joy0)
			else fail_value("register joystick_0", m_joy0, joystick_0);
		assert ({16'd0, joystick_1} == m_joy1)
			else fail_value("register joystick_1", m_joy1, joystick_1);
		assert (status == m_status)
			else fail_value("register status", m_status, status);
	endtask

	task automatic queue_bytes(input int first, input int count);
		logic [7:0] b;
		int         a;
		for (int i = 0; i < count; i++) begin
			b = rand_byte();
			a = first + i;
			dl_exp_q.push_back({a[24:0], b});
			payload_q.push_back({8'd0, b});
		end
	endtask

	// data is sampled while the device clock is low
	task automatic capture_frame(input int clk_sel, input int dat_sel, output logic [10:0] f);
		for (int i = 0; i <= 10; i++) begin
			wait_line(clk_sel, 1'b0);
			f[i] = ps2_line(dat_sel);
			wait_line(clk_sel, 1'b1);
		end
	endtask

	task automatic send_frames(input logic [15:0] cmd, input int clk_sel, input int dat_sel,
		input string name);
		logic [7:0]  b;
		logic [10:0] f;
		frame_test = name;
		for (int i = 0; i < 3; i++) begin
			b = rand_byte();
			frame_exp_q.push_back(ps2_frame(b));
			payload_q.push_back({8'd0, b});
		end
		bus_command(cmd);
		for (int i = 0; i < 3; i++) begin
			capture_frame(clk_sel, dat_sel, f);
			frame_act_q.push_back(f);
		end
		do @(negedge clk_sys); while (frame_act_q.size() != 0);
	endtask

	task automatic host_send_kbd(input logic [7:0] b);
		logic [10:0] f;
		f = ps2_frame(b);
		// inhibit, data low, then release the clock as request to send
		@(posedge clk_sys);
		ps2_kbd_clk_in <= 1'b0;
		repeat (100) @(posedge clk_sys);
		ps2_kbd_data_in <= 1'b0;
		repeat (100) @(posedge clk_sys);
		ps2_kbd_clk_in <= 1'b1;
		// data, parity and stop change while the device holds its clock low
		for (int i = 1; i <= 10; i++) begin
			wait_line(line_kbd_clk, 1'b0);
			@(posedge clk_sys);
			ps2_kbd_data_in <= f[i];
			wait_line(line_kbd_clk, 1'b1);
		end
		// acknowledge pulse from the device
		wait_line(line_kbd_data, 1'b0);
		wait_line(line_kbd_data, 1'b1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// comparison processes
	//////////////////////////////////////////////////////////////////////
	always @(negedge clk_sys) begin : download_compare
		logic [32:0] exp_w;
		if (rst_n && ioctl_wr) begin
			if (dl_exp_q.size() == 0) begin
				fail_text("ioctl_wr pulsed with no download byte outstanding");
			end else begin
				exp_w = dl_exp_q.pop_front();
				assert ({ioctl_addr, ioctl_dout} == exp_w)
					else fail_value("download write", exp_w, {ioctl_addr, ioctl_dout});
				wr_cnt++;
			end
		end
	end

	always @(negedge clk_sys) begin : frame_compare
		logic [10:0] exp_f;
		logic [10:0] act_f;
		if (frame_exp_q.size() != 0 && frame_act_q.size() != 0) begin
			exp_f = frame_exp_q.pop_front();
			act_f = frame_act_q.pop_front();
			assert (act_f == exp_f) else fail_value(frame_test, exp_f, act_f);
		end
		if (kbd_quiet) begin
			assert (ps2_kbd_clk_out && ps2_kbd_data_out)
				else fail_text("keyboard PS/2 lines moved during the mouse transfer");
		end
	end

	initial begin : main
		logic [7:0] idx;
		logic [7:0] b;
		repeat (10) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(negedge clk_sys);
		assert ({io_dout, ioctl_wr, ioctl_download, ps2_kbd_clk_out, ps2_kbd_data_out,
			ps2_mouse_clk_out, ps2_mouse_data_out} == {16'd0, 2'b00, 4'hf})
			else fail_text("outputs not idle after reset");

		// configuration, joysticks and status
		for (int r = 0; r < 4; r++) begin
			reg_write(cmd_cfg, m_cfg);
			reg_write(cmd_joy0, m_joy0);
			reg_write(cmd_joy1, m_joy1);
			reg_write(cmd_status, m_status);
			check_regs();
		end

		// file download, second half sent while the core holds ioctl_wait
		idx = rand_byte();
		payload_q.push_back({8'd0, idx});
		bus_command(cmd_file_index);
		payload_q.push_back(16'h0001);
		bus_command(cmd_file_tx);
		@(negedge clk_sys);
		assert (ioctl_index == idx) else fail_value("download index", idx, ioctl_index);
		assert (ioctl_download) else fail_text("ioctl_download did not rise on start");
		queue_bytes(0, 8);
		bus_command(cmd_file_tx_dat);
		queue_bytes(8, 8);
		@(posedge clk_sys);
		ioctl_wait <= 1'b1;
		fork
			bus_command(cmd_file_tx_dat);
			begin
				repeat (20) begin
					@(negedge clk_sys);
					assert (io_wait) else fail_text("io_wait low while ioctl_wait is held");
				end
				assert (wr_cnt == 8) else fail_value("download stall", 8, wr_cnt);
				@(posedge clk_sys);
				ioctl_wait <= 1'b0;
			end
		join
		payload_q.push_back(16'h0000);
		bus_command(cmd_file_tx);
		@(negedge clk_sys);
		assert (!io_wait) else fail_text("io_wait stuck high after ioctl_wait release");
		assert (!ioctl_download) else fail_text("ioctl_download still high after stop");
		assert (wr_cnt == 16) else fail_value("download write count", 16, wr_cnt);

		send_frames(cmd_kbd, line_kbd_clk, line_kbd_data, "keyboard frame");

		// host to keyboard byte and its read-back
		b = rand_byte();
		host_send_kbd(b);
		payload_q.push_back(16'h0000);
		bus_command(cmd_ps2_read);
		assert (last_dout == {7'd0, 1'b1, b})
			else fail_value("keyboard read-back", {7'd0, 1'b1, b}, last_dout);
		payload_q.push_back(16'h0000);
		bus_command(cmd_ps2_read);
		assert (last_dout[8] == 1'b0)
			else fail_value("keyboard second read flag", 0, last_dout[8]);

		kbd_quiet = 1'b1;
		send_frames(cmd_mouse, line_mouse_clk, line_mouse_data, "mouse frame");
		kbd_quiet = 1'b0;

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hps_io.f
hdl/hps_io_pkg.sv
hdl/ps2_host_if.sv
hdl/hps_cmd_decoder.sv
hdl/file_download.sv
hdl/ps2_device.sv
hdl/hps_io.sv
sim/tb_hps_io.sv

// File: Makefile
# Verilator build and run for the hps i/o bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_hps_io
FILELIST  ?= hps_io.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "All checks passed" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
